/* rtl/hl_ctrl_settings.svh */
`ifndef HL_CTRL_SETTINGS_SVH
`define HL_CTRL_SETTINGS_SVH

// Quarter-millisecond down-counter reload, one tick every 626 clocks
`define HL_QMSEC_RELOAD 625

// Millisecond ticks a new pin level must persist
`define HL_DEBOUNCE_MS 3

// Transmit-control command and its data bits
`define HL_CMD_TXCTRL 6'h09
`define HL_TXCTRL_VNA_BIT 23
`define HL_TXCTRL_PA_EN_BIT 19
`define HL_TXCTRL_TR_DIS_BIT 18

`define HL_VERSION_MAJOR 8'd72

// ADC codes, code = ((T*0.01 + 0.5) / 3.26) * 4096
`define HL_TEMP_30C 12'h3ED
`define HL_TEMP_35C 12'h42B
`define HL_TEMP_40C 12'h46B
`define HL_TEMP_45C 12'h4AA
`define HL_TEMP_50C 12'h4E8
`define HL_TEMP_55C 12'h527

`define HL_FAN_CNT_BITS 16

`endif

/* rtl/hl_ctrl_pkg.sv */
package hl_ctrl_pkg;

  // Slow ADC reading
  typedef logic [11:0] adc_word_t;

  // Word handed back to the host on each response request
  typedef logic [39:0] resp_word_t;

  typedef logic [5:0]  cmd_addr_t;
  typedef logic [31:0] cmd_data_t;

  // Adjacent states differ in one bit
  typedef enum logic [2:0] {
    FAN_OFF      = 3'b000,
    FAN_LOW      = 3'b001,
    FAN_MED      = 3'b011,
    FAN_FULL     = 3'b010,
    FAN_OVERHEAT = 3'b110
  } fan_state_e;

  typedef enum logic [1:0] {
    SLOT_STATUS   = 2'd0,
    SLOT_TEMP_FWD = 2'd1,
    SLOT_REV_BIAS = 2'd2,
    SLOT_SPARE    = 2'd3
  } resp_slot_e;

endpackage

/* rtl/ms_tick_gen.sv */
`include "hl_ctrl_settings.svh"

module ms_tick_gen (
  input  logic clk,
  input  logic slow_adc_rst,
  output logic qmsec_pulse_o,
  output logic msec_pulse_o
);

  localparam int QMS_W = $clog2(`HL_QMSEC_RELOAD + 1);

  logic [QMS_W-1:0] qms_cnt;
  logic [1:0]       ms_div;
  logic             qms_wrap;

  assign qms_wrap = (qms_cnt == '0);

  always_ff @(posedge clk) begin
    if (slow_adc_rst) begin
      qms_cnt       <= QMS_W'(`HL_QMSEC_RELOAD);
      ms_div        <= 2'd0;
      qmsec_pulse_o <= 1'b0;
      msec_pulse_o  <= 1'b0;
    end else begin
      qmsec_pulse_o <= qms_wrap;
      // Every fourth quarter tick
      msec_pulse_o  <= qms_wrap & (ms_div == 2'd3);
      if (qms_wrap) begin
        qms_cnt <= QMS_W'(`HL_QMSEC_RELOAD);
        ms_div  <= ms_div + 2'd1;
      end else begin
        qms_cnt <= qms_cnt - QMS_W'(1);
      end
    end
  end

endmodule

/* rtl/debounce.sv */
`include "hl_ctrl_settings.svh"

module debounce (
  input  logic clk,
  input  logic slow_adc_rst,
  input  logic msec_pulse_i,
  input  logic raw_n_i,
  output logic level_o
);

  localparam int CNT_W = $clog2(`HL_DEBOUNCE_MS + 1);

  logic [1:0]       sync_q;
  logic [CNT_W-1:0] stable_cnt;

  always_ff @(posedge clk) begin
    if (slow_adc_rst) begin
      sync_q     <= 2'b00;
      stable_cnt <= '0;
      level_o    <= 1'b0;
    end else begin
      // Pin is active low, flip it on the way in
      sync_q <= {sync_q[0], ~raw_n_i};
      if (sync_q[1] == level_o) begin
        stable_cnt <= '0;
      end else if (msec_pulse_i) begin
        // First tick may be partial, so one extra is required
        if (stable_cnt == CNT_W'(`HL_DEBOUNCE_MS)) begin
          level_o    <= sync_q[1];
          stable_cnt <= '0;
        end else begin
          stable_cnt <= stable_cnt + CNT_W'(1);
        end
      end
    end
  end

endmodule

/* rtl/tr_switch_ctrl.sv */
`include "hl_ctrl_settings.svh"

module tr_switch_ctrl (
  input  logic                   clk,
  input  logic                   slow_adc_rst,
  input  logic                   cmd_rqst_i,
  input  hl_ctrl_pkg::cmd_addr_t cmd_addr_i,
  input  hl_ctrl_pkg::cmd_data_t cmd_data_i,
  input  logic                   tx_on_i,
  input  logic                   run_i,
  input  logic                   ext_ptt_i,
  input  logic                   ext_txinhibit_i,
  input  logic                   temp_enabletx_i,
  output logic                   int_tx_on_o,
  output logic                   ptt_resp_o,
  output logic                   pwr_envop_o,
  output logic                   pwr_envpa_o,
  output logic                   pwr_envbias_o,
  output logic                   pa_inttr_o,
  output logic                   pa_exttr_o,
  output logic                   rffe_rfsw_sel_o
);

  logic vna;
  logic pa_enable;
  logic tr_disable;

  always_ff @(posedge clk) begin
    if (slow_adc_rst) begin
      vna        <= 1'b0;
      pa_enable  <= 1'b0;
      tr_disable <= 1'b0;
    end else if (cmd_rqst_i && (cmd_addr_i == `HL_CMD_TXCTRL)) begin
      vna        <= cmd_data_i[`HL_TXCTRL_VNA_BIT];
      pa_enable  <= cmd_data_i[`HL_TXCTRL_PA_EN_BIT];
      tr_disable <= cmd_data_i[`HL_TXCTRL_TR_DIS_BIT];
    end
  end

  // Ring input doubles as external PTT
  assign ptt_resp_o = ext_ptt_i;

  assign int_tx_on_o = (tx_on_i | ext_ptt_i) & ~ext_txinhibit_i & run_i & temp_enabletx_i;

  assign pwr_envop_o     = int_tx_on_o;
  assign pa_exttr_o      = int_tx_on_o;
  assign pwr_envpa_o     = int_tx_on_o & ~vna & pa_enable;
  assign pwr_envbias_o   = int_tx_on_o & ~vna & pa_enable;
  // Internal T/R relay still switches with the PA off unless disabled
  assign pa_inttr_o      = int_tx_on_o & ~vna & (pa_enable | ~tr_disable);
  assign rffe_rfsw_sel_o = ~vna & pa_enable;

endmodule

/* rtl/fan_thermal_ctrl.sv */
`include "hl_ctrl_settings.svh"

module fan_thermal_ctrl (
  input  logic                   clk,
  input  logic                   slow_adc_rst,
  input  logic                   adc_sample_i,
  input  hl_ctrl_pkg::adc_word_t temperature_i,
  output logic                   fan_pwm_o,
  output logic                   temp_enabletx_o
);

  localparam int TOP = `HL_FAN_CNT_BITS - 1;

  hl_ctrl_pkg::fan_state_e fan_state_q;
  hl_ctrl_pkg::fan_state_e fan_state_d;
  hl_ctrl_pkg::fan_state_e state_up;
  hl_ctrl_pkg::fan_state_e state_dn;

  logic [TOP:0] fan_cnt;
  logic [1:0]   up_vote_q;
  logic [1:0]   up_vote_d;
  logic [1:0]   dn_vote_q;
  logic [1:0]   dn_vote_d;
  logic         up_hit;
  logic         dn_hit;

  always_ff @(posedge clk) begin
    if (slow_adc_rst) begin
      fan_cnt     <= '0;
      fan_state_q <= hl_ctrl_pkg::FAN_OFF;
      up_vote_q   <= 2'd0;
      dn_vote_q   <= 2'd0;
    end else begin
      fan_cnt <= fan_cnt + 1'b1;
      if (adc_sample_i) begin
        fan_state_q <= fan_state_d;
        up_vote_q   <= up_vote_d;
        dn_vote_q   <= dn_vote_d;
      end
    end
  end

  // Thresholds and neighbours of the current state
  always_comb begin
    up_hit   = 1'b0;
    dn_hit   = 1'b0;
    state_up = fan_state_q;
    state_dn = fan_state_q;
    case (fan_state_q)
      hl_ctrl_pkg::FAN_OFF: begin
        up_hit   = temperature_i > `HL_TEMP_35C;
        state_up = hl_ctrl_pkg::FAN_LOW;
      end
      hl_ctrl_pkg::FAN_LOW: begin
        up_hit   = temperature_i > `HL_TEMP_40C;
        dn_hit   = temperature_i < `HL_TEMP_30C;
        state_up = hl_ctrl_pkg::FAN_MED;
        state_dn = hl_ctrl_pkg::FAN_OFF;
      end
      hl_ctrl_pkg::FAN_MED: begin
        up_hit   = temperature_i > `HL_TEMP_45C;
        dn_hit   = temperature_i < `HL_TEMP_35C;
        state_up = hl_ctrl_pkg::FAN_FULL;
        state_dn = hl_ctrl_pkg::FAN_LOW;
      end
      hl_ctrl_pkg::FAN_FULL: begin
        up_hit   = temperature_i > `HL_TEMP_55C;
        dn_hit   = temperature_i < `HL_TEMP_40C;
        state_up = hl_ctrl_pkg::FAN_OVERHEAT;
        state_dn = hl_ctrl_pkg::FAN_MED;
      end
      hl_ctrl_pkg::FAN_OVERHEAT: begin
        dn_hit   = temperature_i < `HL_TEMP_50C;
        state_dn = hl_ctrl_pkg::FAN_FULL;
      end
      default: begin
        // Unused codes vote their way back to off
        dn_hit   = 1'b1;
        state_dn = hl_ctrl_pkg::FAN_OFF;
      end
    endcase
  end

  // Votes saturate at 3 and leak back towards 0
  always_comb begin
    up_vote_d = up_hit ? ((&up_vote_q) ? up_vote_q : up_vote_q + 2'd1)
                       : ((up_vote_q == 2'd0) ? up_vote_q : up_vote_q - 2'd1);
    dn_vote_d = dn_hit ? ((&dn_vote_q) ? dn_vote_q : dn_vote_q + 2'd1)
                       : ((dn_vote_q == 2'd0) ? dn_vote_q : dn_vote_q - 2'd1);
    fan_state_d = fan_state_q;
    if (up_hit && (&up_vote_q)) begin
      fan_state_d = state_up;
    end else if (dn_hit && (&dn_vote_q)) begin
      fan_state_d = state_dn;
    end
    // Fresh votes in the new state
    if (fan_state_d != fan_state_q) begin
      up_vote_d = 2'd0;
      dn_vote_d = 2'd0;
    end
  end

  always_comb begin
    case (fan_state_q)
      hl_ctrl_pkg::FAN_LOW:      fan_pwm_o = fan_cnt[TOP];
      hl_ctrl_pkg::FAN_MED:      fan_pwm_o = fan_cnt[TOP] | fan_cnt[TOP-1];
      hl_ctrl_pkg::FAN_FULL:     fan_pwm_o = 1'b1;
      hl_ctrl_pkg::FAN_OVERHEAT: fan_pwm_o = 1'b1;
      default:                   fan_pwm_o = 1'b0;
    endcase
  end

  assign temp_enabletx_o = (fan_state_q != hl_ctrl_pkg::FAN_OVERHEAT);

endmodule

/* rtl/resp_frame_builder.sv */
`include "hl_ctrl_settings.svh"

module resp_frame_builder (
  input  logic                    clk,
  input  logic                    slow_adc_rst,
  input  logic                    cmd_rqst_i,
  input  logic                    cmd_requires_resp_i,
  input  hl_ctrl_pkg::cmd_addr_t  cmd_addr_i,
  input  hl_ctrl_pkg::cmd_data_t  cmd_data_i,
  input  logic                    resp_rqst_i,
  input  logic                    ext_cwkey_i,
  input  logic                    ptt_resp_i,
  input  logic                    rxclip_i,
  input  logic [7:0]              dsiq_status_i,
  input  hl_ctrl_pkg::adc_word_t  temperature_i,
  input  hl_ctrl_pkg::adc_word_t  fwd_pwr_i,
  input  hl_ctrl_pkg::adc_word_t  rev_pwr_i,
  input  hl_ctrl_pkg::adc_word_t  bias_current_i,
  output hl_ctrl_pkg::resp_word_t resp_o,
  output logic                    adc_sample_o
);

  // Status slot 0 with key, PTT and clip all clear
  localparam hl_ctrl_pkg::resp_word_t RESP_INIT =
    {8'h00, 7'b0001111, 1'b0, 8'h00, 8'h00, `HL_VERSION_MAJOR};

  hl_ctrl_pkg::resp_slot_e slot_q;
  hl_ctrl_pkg::cmd_addr_t  pend_addr;
  hl_ctrl_pkg::cmd_data_t  pend_data;
  hl_ctrl_pkg::resp_word_t status_word;

  logic        pend_q;
  logic        phase_q;
  logic [1:0]  clip_cnt;
  logic        clip_sat;
  logic        cmd_capture;
  logic        deliver;
  logic [31:0] slot_payload;

  assign cmd_capture = cmd_rqst_i & cmd_requires_resp_i;
  // Command answers only go out on even requests
  assign deliver      = resp_rqst_i & pend_q & ~phase_q;
  assign clip_sat     = &clip_cnt;
  assign adc_sample_o = resp_rqst_i & phase_q;

  always_comb begin
    case (slot_q)
      hl_ctrl_pkg::SLOT_STATUS:
        slot_payload = {7'b0001111, clip_sat, 8'h00, dsiq_status_i, `HL_VERSION_MAJOR};
      hl_ctrl_pkg::SLOT_TEMP_FWD:
        slot_payload = {4'h0, temperature_i, 4'h0, fwd_pwr_i};
      hl_ctrl_pkg::SLOT_REV_BIAS:
        slot_payload = {4'h0, rev_pwr_i, 4'h0, bias_current_i};
      default:
        slot_payload = 32'h0;
    endcase
  end

  assign status_word = {3'b000, slot_q, ext_cwkey_i, 1'b0, ptt_resp_i, slot_payload};

  // Single-entry queue, a newer command replaces the old one
  always_ff @(posedge clk) begin
    if (cmd_capture) begin
      pend_addr <= cmd_addr_i;
      pend_data <= cmd_data_i;
    end
  end

  always_ff @(posedge clk) begin
    if (slow_adc_rst) begin
      resp_o   <= RESP_INIT;
      pend_q   <= 1'b0;
      phase_q  <= 1'b0;
      slot_q   <= hl_ctrl_pkg::SLOT_STATUS;
      clip_cnt <= 2'b00;
    end else begin
      if (cmd_capture) begin
        pend_q <= 1'b1;
      end else if (deliver) begin
        pend_q <= 1'b0;
      end

      if (resp_rqst_i) begin
        phase_q  <= ~phase_q;
        clip_cnt <= 2'b00;
        // Pointer moves on even when a command answer takes the slot
        slot_q   <= hl_ctrl_pkg::resp_slot_e'(slot_q + 2'd1);
        if (deliver) begin
          resp_o <= {1'b1, pend_addr, ptt_resp_i, pend_data};
        end else begin
          resp_o <= status_word;
        end
      end else if (!clip_sat) begin
        clip_cnt <= clip_cnt + {1'b0, rxclip_i};
      end
    end
  end

endmodule

/* rtl/hl_ctrl_top.sv */
module hl_ctrl_top (
  input  logic                    clk,
  input  logic                    slow_adc_rst,
  input  logic                    cmd_rqst_i,
  input  hl_ctrl_pkg::cmd_addr_t  cmd_addr_i,
  input  hl_ctrl_pkg::cmd_data_t  cmd_data_i,
  input  logic                    cmd_requires_resp_i,
  input  logic                    resp_rqst_i,
  input  logic                    tx_on_i,
  input  logic                    run_i,
  input  logic                    io_tx_inhibit_i,
  input  logic                    io_phone_ring_i,
  input  logic                    io_phone_tip_i,
  input  logic                    rxclip_i,
  input  logic [7:0]              dsiq_status_i,
  input  hl_ctrl_pkg::adc_word_t  temperature_i,
  input  hl_ctrl_pkg::adc_word_t  fwd_pwr_i,
  input  hl_ctrl_pkg::adc_word_t  rev_pwr_i,
  input  hl_ctrl_pkg::adc_word_t  bias_current_i,
  output logic                    qmsec_pulse_o,
  output logic                    msec_pulse_o,
  output logic                    int_tx_on_o,
  output logic                    ptt_resp_o,
  output logic                    pwr_envop_o,
  output logic                    pwr_envpa_o,
  output logic                    pwr_envbias_o,
  output logic                    pa_inttr_o,
  output logic                    pa_exttr_o,
  output logic                    rffe_rfsw_sel_o,
  output logic                    fan_pwm_o,
  output logic                    temp_enabletx_o,
  output hl_ctrl_pkg::resp_word_t resp_o,
  output logic                    adc_sample_o
);

  logic ext_txinhibit;
  logic clean_ring;
  logic ext_cwkey;

  ms_tick_gen u_ticks (
    .clk           (clk),
    .slow_adc_rst  (slow_adc_rst),
    .qmsec_pulse_o (qmsec_pulse_o),
    .msec_pulse_o  (msec_pulse_o)
  );

  debounce de_tx_inhibit (
    .clk          (clk),
    .slow_adc_rst (slow_adc_rst),
    .msec_pulse_i (msec_pulse_o),
    .raw_n_i      (io_tx_inhibit_i),
    .level_o      (ext_txinhibit)
  );

  debounce de_phone_ring (
    .clk          (clk),
    .slow_adc_rst (slow_adc_rst),
    .msec_pulse_i (msec_pulse_o),
    .raw_n_i      (io_phone_ring_i),
    .level_o      (clean_ring)
  );

  // Tip is the CW key, reported in the response word only
  debounce de_phone_tip (
    .clk          (clk),
    .slow_adc_rst (slow_adc_rst),
    .msec_pulse_i (msec_pulse_o),
    .raw_n_i      (io_phone_tip_i),
    .level_o      (ext_cwkey)
  );

  tr_switch_ctrl u_tr_switch (
    .clk             (clk),
    .slow_adc_rst    (slow_adc_rst),
    .cmd_rqst_i      (cmd_rqst_i),
    .cmd_addr_i      (cmd_addr_i),
    .cmd_data_i      (cmd_data_i),
    .tx_on_i         (tx_on_i),
    .run_i           (run_i),
    .ext_ptt_i       (clean_ring),
    .ext_txinhibit_i (ext_txinhibit),
    .temp_enabletx_i (temp_enabletx_o),
    .int_tx_on_o     (int_tx_on_o),
    .ptt_resp_o      (ptt_resp_o),
    .pwr_envop_o     (pwr_envop_o),
    .pwr_envpa_o     (pwr_envpa_o),
    .pwr_envbias_o   (pwr_envbias_o),
    .pa_inttr_o      (pa_inttr_o),
    .pa_exttr_o      (pa_exttr_o),
    .rffe_rfsw_sel_o (rffe_rfsw_sel_o)
  );

  fan_thermal_ctrl u_fan (
    .clk             (clk),
    .slow_adc_rst    (slow_adc_rst),
    .adc_sample_i    (adc_sample_o),
    .temperature_i   (temperature_i),
    .fan_pwm_o       (fan_pwm_o),
    .temp_enabletx_o (temp_enabletx_o)
  );

  resp_frame_builder u_resp (
    .clk                 (clk),
    .slow_adc_rst        (slow_adc_rst),
    .cmd_rqst_i          (cmd_rqst_i),
    .cmd_requires_resp_i (cmd_requires_resp_i),
    .cmd_addr_i          (cmd_addr_i),
    .cmd_data_i          (cmd_data_i),
    .resp_rqst_i         (resp_rqst_i),
    .ext_cwkey_i         (ext_cwkey),
    .ptt_resp_i          (ptt_resp_o),
    .rxclip_i            (rxclip_i),
    .dsiq_status_i       (dsiq_status_i),
    .temperature_i       (temperature_i),
    .fwd_pwr_i           (fwd_pwr_i),
    .rev_pwr_i           (rev_pwr_i),
    .bias_current_i      (bias_current_i),
    .resp_o              (resp_o),
    .adc_sample_o        (adc_sample_o)
  );

endmodule

/* tests/hl_ctrl_tb.sv */
module hl_ctrl_tb;
  timeunit 1ns;
  timeprecision 100ps;

  // Design constants restated for the checks
  localparam int          QMS_PERIOD  = 626;
  localparam int          DEBOUNCE_MS = 3;
  localparam logic [7:0]  VERSION     = 8'd72;
  localparam logic [11:0] TEMP_MID    = 12'h400;
  localparam logic [11:0] TEMP_HOT    = 12'h600;
  localparam logic [11:0] TEMP_COLD   = 12'h300;
  localparam int          TICK_LIMIT  = (DEBOUNCE_MS + 2) * 4 * QMS_PERIOD;

  logic        clk;
  logic        slow_adc_rst;
  logic        cmd_rqst_i;
  logic [5:0]  cmd_addr_i;
  logic [31:0] cmd_data_i;
  logic        cmd_requires_resp_i;
  logic        resp_rqst_i;
  logic        tx_on_i;
  logic        run_i;
  logic        io_tx_inhibit_i;
  logic        io_phone_ring_i;
  logic        io_phone_tip_i;
  logic        rxclip_i;
  logic [7:0]  dsiq_status_i;
  logic [11:0] temperature_i;
  logic [11:0] fwd_pwr_i;
  logic [11:0] rev_pwr_i;
  logic [11:0] bias_current_i;
  logic        qmsec_pulse_o;
  logic        msec_pulse_o;
  logic        int_tx_on_o;
  logic        ptt_resp_o;
  logic        pwr_envop_o;
  logic        pwr_envpa_o;
  logic        pwr_envbias_o;
  logic        pa_inttr_o;
  logic        pa_exttr_o;
  logic        rffe_rfsw_sel_o;
  logic        fan_pwm_o;
  logic        temp_enabletx_o;
  logic [39:0] resp_o;
  logic        adc_sample_o;

  integer seed;
  // Expected phase of the next response request
  logic   phase_exp;

  hl_ctrl_top DUT (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1, "run stopped");
  endtask

  task automatic check(input string name, input logic [63:0] expected,
                       input logic [63:0] actual);
    if (actual !== expected) begin
      $display("FAIL %s expected %0h actual %0h", name, expected, actual);
      $display("tests failed");
      $fatal(1, "run stopped");
    end
  endtask

  task automatic wait_qmsec(output int cycles);
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
      if (cycles > QMS_PERIOD + 8) begin
        stop_run("no quarter-millisecond tick arrived in time");
      end
    end while (!qmsec_pulse_o);
  endtask

  task automatic wait_msec();
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
      if (cycles > 4 * QMS_PERIOD + 8) begin
        stop_run("no millisecond tick arrived in time");
      end
    end while (!msec_pulse_o);
  endtask

  // Pin changes are made right after a tick, so ticks count from zero
  task automatic wait_tx_level(input logic level, input string what);
    int ticks;
    int cycles;
    ticks = 0;
    cycles = 0;
    while (int_tx_on_o !== level) begin
      @(negedge clk);
      cycles++;
      if (msec_pulse_o) begin
        ticks++;
      end
      if (ticks > DEBOUNCE_MS + 1 || cycles > TICK_LIMIT) begin
        stop_run({"transmit level did not settle after ", what});
      end
    end
  endtask

  task automatic send_cmd(input logic [5:0] addr, input logic [31:0] data,
                          input logic need_resp);
    @(negedge clk);
    cmd_rqst_i          = 1'b1;
    cmd_addr_i          = addr;
    cmd_data_i          = data;
    cmd_requires_resp_i = need_resp;
    @(negedge clk);
    cmd_rqst_i          = 1'b0;
    cmd_requires_resp_i = 1'b0;
  endtask

  task automatic request_resp(input string name, output logic [39:0] word);
    @(negedge clk);
    resp_rqst_i = 1'b1;
    #1;
    check({name, " adc_sample"}, 64'(phase_exp), 64'(adc_sample_o));
    @(negedge clk);
    resp_rqst_i = 1'b0;
    phase_exp   = ~phase_exp;
    word        = resp_o;
  endtask

  task automatic pwm_steady(input string name, input logic level, input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      check(name, 64'(level), 64'(fan_pwm_o));
    end
  endtask

  // Status frame with key and PTT released
  function automatic logic [39:0] status_word(input logic [1:0] slot,
                                              input logic [31:0] payload);
    return {3'b000, slot, 1'b0, 1'b0, 1'b0, payload};
  endfunction

  // One transmit-control command per vector line, then the PA outputs
  task automatic run_vectors();
    int              fd;
    int              code;
    int              count;
    logic [8*24-1:0] vname;
    logic [8*96-1:0] skip;
    logic [31:0]     v_addr;
    logic [31:0]     v_data;
    logic [31:0]     v_tx;
    logic [31:0]     v_run;
    logic [31:0]     v_exp;
    count = 0;
    fd = $fopen("tests/hl_ctrl_vectors.txt", "r");
    if (fd == 0) begin
      stop_run("cannot open tests/hl_ctrl_vectors.txt");
    end else begin
      code = $fscanf(fd, "%s", vname);
      while (code == 1 && count < 64) begin
        if (vname[7:0] == "#") begin
          code = $fgets(skip, fd);
        end else begin
          code = $fscanf(fd, "%h %h %b %b %b", v_addr, v_data, v_tx, v_run, v_exp);
          if (code != 5) begin
            stop_run("malformed line in the vector file");
          end
          tx_on_i = v_tx[0];
          run_i   = v_run[0];
          send_cmd(v_addr[5:0], v_data, 1'b0);
          check($sformatf("%0s", vname), 64'(v_exp[5:0]),
                64'({pwr_envop_o, pwr_envpa_o, pwr_envbias_o,
                     pa_inttr_o, pa_exttr_o, rffe_rfsw_sel_o}));
          count++;
        end
        code = $fscanf(fd, "%s", vname);
      end
      $fclose(fd);
    end
    if (count == 0) begin
      stop_run("no vectors were read");
    end
  endtask

  initial begin
    int          cycles;
    logic [39:0] word;
    logic [31:0] cmd_data;
    seed                = 32'hd34ed75f;
    slow_adc_rst        = 1'b1;
    cmd_rqst_i          = 1'b0;
    cmd_addr_i          = '0;
    cmd_data_i          = '0;
    cmd_requires_resp_i = 1'b0;
    resp_rqst_i         = 1'b0;
    tx_on_i             = 1'b0;
    run_i               = 1'b0;
    io_tx_inhibit_i     = 1'b1;
    io_phone_ring_i     = 1'b1;
    io_phone_tip_i      = 1'b1;
    rxclip_i            = 1'b0;
    dsiq_status_i       = 8'ha5;
    temperature_i       = TEMP_MID;
    fwd_pwr_i           = 12'($random(seed));
    rev_pwr_i           = 12'($random(seed));
    bias_current_i      = 12'($random(seed));
    phase_exp           = 1'b0;
    repeat (8) @(negedge clk);
    slow_adc_rst = 1'b0;

    // Tick spacing from reset release
    for (int k = 1; k <= 4; k++) begin
      wait_qmsec(cycles);
      check("qmsec_period", 64'(QMS_PERIOD), 64'(cycles));
      check("msec_with_qmsec", 64'(k == 4), 64'(msec_pulse_o));
    end

    run_vectors();

    // Inhibit pin cuts transmit
    tx_on_i = 1'b1;
    run_i   = 1'b1;
    wait_msec();
    io_tx_inhibit_i = 1'b0;
    wait_tx_level(1'b0, "inhibit");
    check("inhibit_exttr", 64'(0), 64'(pa_exttr_o));
    check("inhibit_envpa", 64'(0), 64'(pwr_envpa_o));
    wait_msec();
    io_tx_inhibit_i = 1'b1;
    wait_tx_level(1'b1, "inhibit release");

    // Ring held low across one tick only
    tx_on_i = 1'b0;
    wait_msec();
    io_phone_ring_i = 1'b0;
    wait_msec();
    io_phone_ring_i = 1'b1;
    repeat (DEBOUNCE_MS + 2) begin
      wait_msec();
      check("ring_glitch", 64'(0), 64'(int_tx_on_o));
    end

    wait_msec();
    io_phone_ring_i = 1'b0;
    wait_tx_level(1'b1, "ring ptt");
    check("ring_ptt_resp", 64'(1), 64'(ptt_resp_o));
    check("ring_exttr", 64'(1), 64'(pa_exttr_o));
    wait_msec();
    io_phone_ring_i = 1'b1;
    wait_tx_level(1'b0, "ring release");

    // Status slots in turn, clip saturated for slot 0
    rxclip_i = 1'b1;
    repeat (4) @(negedge clk);
    rxclip_i = 1'b0;
    request_resp("slot0_clip", word);
    check("slot0_clip", 64'(status_word(2'd0,
          {7'b0001111, 1'b1, 8'h00, dsiq_status_i, VERSION})), 64'(word));
    request_resp("slot1_temp_fwd", word);
    check("slot1_temp_fwd", 64'(status_word(2'd1,
          {4'h0, temperature_i, 4'h0, fwd_pwr_i})), 64'(word));
    request_resp("slot2_rev_bias", word);
    check("slot2_rev_bias", 64'(status_word(2'd2,
          {4'h0, rev_pwr_i, 4'h0, bias_current_i})), 64'(word));
    request_resp("slot3_spare", word);
    check("slot3_spare", 64'(status_word(2'd3, 32'h0)), 64'(word));

    // Command answer waits for an even request
    request_resp("cmd_slot0", word);
    check("cmd_slot0", 64'(status_word(2'd0,
          {7'b0001111, 1'b0, 8'h00, dsiq_status_i, VERSION})), 64'(word));
    cmd_data = $random(seed);
    send_cmd(6'h15, cmd_data, 1'b1);
    request_resp("cmd_odd_request", word);
    check("cmd_odd_request", 64'(status_word(2'd1,
          {4'h0, temperature_i, 4'h0, fwd_pwr_i})), 64'(word));
    request_resp("cmd_resp", word);
    check("cmd_resp", 64'({1'b1, 6'h15, 1'b0, cmd_data}), 64'(word));
    request_resp("cmd_slot_skip", word);
    check("cmd_slot_skip", 64'(status_word(2'd3, 32'h0)), 64'(word));
    request_resp("cmd_cleared", word);
    check("cmd_cleared", 64'(status_word(2'd0,
          {7'b0001111, 1'b0, 8'h00, dsiq_status_i, VERSION})), 64'(word));

    // Four states up, four samples each
    temperature_i = TEMP_HOT;
    tx_on_i       = 1'b1;
    for (int i = 1; i <= 16; i++) begin
      request_resp("heat", word);
      request_resp("heat", word);
      check("heat_enable_tx", 64'(i < 16), 64'(temp_enabletx_o));
    end
    check("overheat_exttr", 64'(0), 64'(pa_exttr_o));
    pwm_steady("overheat_pwm", 1'b1, 1024);

    temperature_i = TEMP_COLD;
    for (int i = 1; i <= 16; i++) begin
      request_resp("cool", word);
      request_resp("cool", word);
      check("cool_enable_tx", 64'(i >= 4), 64'(temp_enabletx_o));
    end
    // A full PWM period, so FAN_LOW would show up
    pwm_steady("cool_pwm", 1'b0, 1 << 16);
    check("cool_exttr", 64'(1), 64'(pa_exttr_o));

    $display("all tests passed");
    $finish;
  end

endmodule

/* tests/hl_ctrl_vectors.txt */
# columns: name, command address (hex), command data (hex), tx_on, run
# expected outputs as binary: envop envpa envbias inttr exttr rfsw_sel
pa_on        09 00080000 1 1 111111
pa_off       09 00000000 1 1 100110
tr_disable   09 00040000 1 1 100010
pa_tr_dis    09 000c0000 1 1 111111
vna          09 00800000 1 1 100010
vna_pa       09 00880000 1 1 100010
other_addr   0a 00080000 1 1 100010
other_bits   09 ff73ffff 1 1 100110
pa_rx        09 00080000 0 1 000001
run_off      09 00080000 1 0 000001
pa_tx        09 00080000 1 1 111111

/* build.f */
+incdir+rtl
rtl/hl_ctrl_pkg.sv
rtl/ms_tick_gen.sv
rtl/debounce.sv
rtl/tr_switch_ctrl.sv
rtl/fan_thermal_ctrl.sv
rtl/resp_frame_builder.sv
rtl/hl_ctrl_top.sv
tests/hl_ctrl_tb.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary -j 0 --top-module hl_ctrl_tb -f build.f -o hl_ctrl_sim
	./obj_dir/hl_ctrl_sim

clean:
	rm -rf obj_dir
